// ==== Makefile ====
# Verilator build and run of the output glue testbench
SIM = obj_dir/Vtb_mm_top

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): files.f src/*.sv src/*.svh tests/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_mm_top -f files.f -Mdir obj_dir

# Pass or fail comes from the log, not from the exit code
run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== files.f ====
+incdir+src
src/mm_av_pkg.sv
src/mm_kbd_pkg.sv
src/sample_fifo.sv
src/audio_pacer.sv
src/kbd_merge.sv
src/video_out.sv
src/mm_top.sv
tests/tb_mm_top.sv

// ==== src/audio_pacer.sv ====
// Pulls one stereo pair from the sample FIFO every MM_AUD_PERIOD cycles.
// Words are stored little-endian, left first; both channels update together,
// 4 cycles after the period start. With fewer than two words the outputs
// hold and aud_underrun pulses on the cycle after the period start.
`timescale 1ns/1ps
`default_nettype none

`include "mm_macros.svh"

module audio_pacer import mm_av_pkg::*; (
	input wire CLK_114,
	input wire rst_n,
	input wire [`MM_FIFO_AW:0] level, // FIFO fill
	input wire sample_t rd_data, // FIFO read port, one cycle late
	output logic rd, // FIFO pop strobe
	output sample_t aud_left,
	output sample_t aud_right,
	output logic aud_strobe, // New pair on the outputs
	output logic aud_underrun // Period skipped, FIFO short
);

	localparam int PERIOD = `MM_AUD_PERIOD;
	localparam int CW = $clog2(PERIOD);
	localparam int HALF = `MM_SAMPLE_W / 2;

	logic [CW-1:0] cnt; // Sample period counter
	pace_state_t state;
	sample_t left_word; // Left word parked until the right arrives
	logic period_start;
	logic pair_ready;

	// Little-endian storage to host order
	function automatic sample_t swap_bytes(input sample_t s);
		return {s[HALF-1:0], s[`MM_SAMPLE_W-1:HALF]};
	endfunction

	assign period_start = (cnt == '0);
	assign pair_ready = (level >= (`MM_FIFO_AW+1)'(2)); // Need both words

	////////////////////////////////////////////////////////////
	// Period counter and fetch sequence
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
			state <= PACE_WAIT;
			rd <= 1'b0;
			aud_left <= '0;
			aud_right <= '0;
			aud_strobe <= 1'b0;
			aud_underrun <= 1'b0;
		end else begin
			cnt <= (cnt == CW'(PERIOD - 1)) ? '0 : cnt + 1'b1;
			rd <= 1'b0; // Strobes default low
			aud_strobe <= 1'b0;
			aud_underrun <= 1'b0;
			case (state)
				PACE_WAIT: begin
					if (period_start && pair_ready) begin
						state <= PACE_POP_L;
						rd <= 1'b1; // Left pop
					end else if (period_start) begin
						aud_underrun <= 1'b1; // Hold previous pair
					end
				end
				PACE_POP_L: begin
					state <= PACE_POP_R;
					rd <= 1'b1; // Right pop
				end
				PACE_POP_R: state <= PACE_LOAD; // Left word on rd_data now
				PACE_LOAD: begin // Right word on rd_data now
					state <= PACE_WAIT;
					aud_left <= swap_bytes(left_word);
					aud_right <= swap_bytes(rd_data);
					aud_strobe <= 1'b1;
				end
				default: state <= PACE_WAIT;
			endcase
		end
	end

	always_ff @(posedge CLK_114) begin
		if (state == PACE_POP_R)
			left_word <= rd_data;
	end

	a_rd_in_pop: assert property (
		@(posedge CLK_114) disable iff (!rst_n)
		rd |-> (state == PACE_POP_L || state == PACE_POP_R)
	) else $error("audio_pacer: pop outside pop states");

endmodule

`default_nettype wire

// ==== src/kbd_merge.sv ====
// Merges key events from the matrix and dock keyboards into one stream.
// Matrix wins a same-cycle collision; a newer event overwrites one not yet sent.
// key_stb is high for one full enable period of MM_KEY_DIV cycles, and
// key_code holds steady for that whole window.
`timescale 1ns/1ps
`default_nettype none

`include "mm_macros.svh"

module kbd_merge import mm_kbd_pkg::*; (
	input wire CLK_114,
	input wire rst_n,
	input wire mat_key_stb, // Matrix key pulse
	input wire key_code_t mat_key,
	input wire dock_key_stb, // Dock key pulse
	input wire key_code_t dock_key,
	output key_code_t key_code,
	output logic key_stb
);

	localparam int DIV = `MM_KEY_DIV;
	localparam int DW = $clog2(DIV);

	logic [DW-1:0] div_cnt; // Free enable counter
	logic tick; // Enable, one cycle per DIV
	key_src_t pend_src; // Who owns the pending code
	key_code_t pend_code;
	logic deliver;

	assign tick = (div_cnt == DW'(DIV - 1));
	// Only start a window when the previous one has closed
	assign deliver = tick && !key_stb && (pend_src != SRC_NONE);

	////////////////////////////////////////////////////////////
	// Enable, pending flag and strobe
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			key_stb <= 1'b0;
			pend_src <= SRC_NONE;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick)
				key_stb <= deliver; // Close window or open a new one
			if (deliver)
				pend_src <= SRC_NONE;
			if (mat_key_stb) // Later assignment wins over the clear
				pend_src <= SRC_MATRIX;
			else if (dock_key_stb)
				pend_src <= SRC_DOCK;
		end
	end

	// Code capture, matrix first
	always_ff @(posedge CLK_114) begin
		if (mat_key_stb)
			pend_code <= mat_key;
		else if (dock_key_stb)
			pend_code <= dock_key;
		if (deliver)
			key_code <= pend_code; // Old code goes out, new one stays pending
	end

	a_code_stable: assert property (
		@(posedge CLK_114) disable iff (!rst_n)
		key_stb |=> !key_stb || $stable(key_code)
	) else $error("kbd_merge: key_code changed inside strobe");

	a_stb_width: assert property (
		@(posedge CLK_114) disable iff (!rst_n)
		$rose(key_stb) |-> ##DIV !key_stb
	) else $error("kbd_merge: strobe not one enable period");

endmodule

`default_nettype wire

// ==== src/mm_av_pkg.sv ====
// Audio and video types shared by the FIFO, the pacer and the video stage.
// Sizes come from the macro header.
`default_nettype none

`include "mm_macros.svh"

package mm_av_pkg;

	typedef logic [`MM_SAMPLE_W-1:0] sample_t; // One FIFO word
	typedef logic [`MM_COLOR_W-1:0] color_t; // One colour channel
	typedef logic [1:0] osd_col_t; // OSD colour, top two bits of a channel

	// OSD palette
	localparam osd_col_t OSD_FG = 2'b11; // Text pixel, white
	localparam osd_col_t OSD_BG_RG = 2'b00; // Background red and green
	localparam osd_col_t OSD_BG_B = 2'b10; // Background blue, dark blue box

	// Pacer sequence, one pass per sample period
	typedef enum logic [1:0] {
		PACE_WAIT = 2'd0, // Idle until period start
		PACE_POP_L = 2'd1, // Left word read strobe
		PACE_POP_R = 2'd2, // Right word read strobe
		PACE_LOAD = 2'd3 // Both channels updated
	} pace_state_t;

endpackage

`default_nettype wire

// ==== src/mm_kbd_pkg.sv ====
// Keyboard types for the key event merger.
`default_nettype none

`include "mm_macros.svh"

package mm_kbd_pkg;

	typedef logic [`MM_KEY_W-1:0] key_code_t; // Raw Amiga key code

	// Source of the pending key event
	typedef enum logic [1:0] {
		SRC_NONE = 2'd0, // Nothing pending
		SRC_MATRIX = 2'd1, // Translated matrix keyboard
		SRC_DOCK = 2'd2 // Docking station keyboard
	} key_src_t;

endpackage

`default_nettype wire

// ==== src/mm_macros.svh ====
// Shared sizes for the output glue, all in CLK_114 cycles or bits.
// MM_FIFO_AW must be log2 of MM_FIFO_DEPTH, and the depth must be a power of two.
// The 28 MHz and 7 MHz rates of the full system are counted enables here.
`ifndef MM_MACROS_SVH
`define MM_MACROS_SVH

////////////////////////////////////////////////////////////
// Video widths
////////////////////////////////////////////////////////////

`define MM_COLOR_W 8 // Internal colour per channel
`define MM_VGA_W 6 // DAC width per channel

////////////////////////////////////////////////////////////
// Audio
////////////////////////////////////////////////////////////

`define MM_SAMPLE_W 16 // Little-endian 16-bit word
`define MM_FIFO_DEPTH 8 // Sample FIFO entries
`define MM_FIFO_AW 3 // FIFO pointer width
`define MM_AUD_PERIOD 2572 // 4 x 643 cycles of 28 MHz, one stereo pair

////////////////////////////////////////////////////////////
// Keyboard
////////////////////////////////////////////////////////////

`define MM_KEY_W 8 // Amiga raw key code
`define MM_KEY_DIV 16 // 7 MHz-class enable divisor

`endif

// ==== src/mm_top.sv ====
// Output glue of the Amiga-clone top level, all on CLK_114.
// Samples enter on a write strobe with no handshake; watch samp_full.
// Key and video inputs are taken as synchronous to CLK_114.
`timescale 1ns/1ps
`default_nettype none

`include "mm_macros.svh"

module mm_top (
	input wire CLK_114,
	input wire rst_n,
	// Samples
	input wire samp_wr,
	input wire [`MM_SAMPLE_W-1:0] samp_data,
	output wire samp_full,
	// Keyboards
	input wire mat_key_stb,
	input wire [`MM_KEY_W-1:0] mat_key,
	input wire dock_key_stb,
	input wire [`MM_KEY_W-1:0] dock_key,
	// Video source and controls
	input wire [`MM_COLOR_W-1:0] src_r,
	input wire [`MM_COLOR_W-1:0] src_g,
	input wire [`MM_COLOR_W-1:0] src_b,
	input wire hsync_in,
	input wire vsync_in,
	input wire csync_in,
	input wire sel_csync,
	input wire hsync_pol,
	input wire vsync_pol,
	input wire osd_window,
	input wire osd_pixel,
	// Audio out
	output wire [`MM_SAMPLE_W-1:0] aud_left,
	output wire [`MM_SAMPLE_W-1:0] aud_right,
	output wire aud_strobe,
	output wire aud_underrun,
	// Keys out
	output wire [`MM_KEY_W-1:0] key_code,
	output wire key_stb,
	// VGA
	output wire [`MM_VGA_W-1:0] vga_r,
	output wire [`MM_VGA_W-1:0] vga_g,
	output wire [`MM_VGA_W-1:0] vga_b,
	output wire vga_hs,
	output wire vga_vs
);

	wire fifo_rd; // Pacer pop
	wire [`MM_SAMPLE_W-1:0] fifo_data;
	wire [`MM_FIFO_AW:0] fifo_level;

	////////////////////////////////////////////////////////////
	// Audio path
	////////////////////////////////////////////////////////////

	sample_fifo u_fifo (
		.CLK_114 (CLK_114),
		.rst_n (rst_n),
		.wr (samp_wr),
		.wr_data (samp_data),
		.rd (fifo_rd),
		.rd_data (fifo_data),
		.full (samp_full),
		.level (fifo_level)
	);

	audio_pacer u_pacer (
		.CLK_114 (CLK_114),
		.rst_n (rst_n),
		.level (fifo_level),
		.rd_data (fifo_data),
		.rd (fifo_rd),
		.aud_left (aud_left),
		.aud_right (aud_right),
		.aud_strobe (aud_strobe),
		.aud_underrun (aud_underrun)
	);

	kbd_merge u_kbd (
		.CLK_114 (CLK_114),
		.rst_n (rst_n),
		.mat_key_stb (mat_key_stb),
		.mat_key (mat_key),
		.dock_key_stb (dock_key_stb),
		.dock_key (dock_key),
		.key_code (key_code),
		.key_stb (key_stb)
	);

	video_out u_video (
		.CLK_114 (CLK_114),
		.rst_n (rst_n),
		.src_r (src_r),
		.src_g (src_g),
		.src_b (src_b),
		.hsync_in (hsync_in),
		.vsync_in (vsync_in),
		.csync_in (csync_in),
		.sel_csync (sel_csync),
		.hsync_pol (hsync_pol),
		.vsync_pol (vsync_pol),
		.osd_window (osd_window),
		.osd_pixel (osd_pixel),
		.vga_r (vga_r),
		.vga_g (vga_g),
		.vga_b (vga_b),
		.vga_hs (vga_hs),
		.vga_vs (vga_vs)
	);

endmodule

`default_nettype wire

// ==== src/sample_fifo.sv ====
// Synchronous FIFO of audio words, MM_FIFO_DEPTH deep.
// A write while full is dropped. Read data is registered and valid the
// cycle after rd. The reader must never pop an empty FIFO.
`timescale 1ns/1ps
`default_nettype none

`include "mm_macros.svh"

module sample_fifo import mm_av_pkg::*; (
	input wire CLK_114,
	input wire rst_n,
	input wire wr, // Write strobe from outside
	input wire sample_t wr_data,
	input wire rd, // Pop strobe from the pacer
	output sample_t rd_data,
	output logic full,
	output logic [`MM_FIFO_AW:0] level // Words held
);

	localparam int DEPTH = `MM_FIFO_DEPTH;
	localparam int AW = `MM_FIFO_AW;

	sample_t mem [DEPTH]; // Storage, no reset
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic wr_ok;

	assign full = (level == (AW+1)'(DEPTH));
	assign wr_ok = wr && !full; // Overflowing writes are lost

	////////////////////////////////////////////////////////////
	// Pointers and level
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1; // Wraps at DEPTH
			if (rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_ok, rd})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level; // Both or neither
			endcase
		end
	end

	// Storage and registered read port
	always_ff @(posedge CLK_114) begin
		if (wr_ok)
			mem[wr_ptr] <= wr_data;
		if (rd)
			rd_data <= mem[rd_ptr]; // Valid next cycle
	end

	// The pacer checks the level before popping, so an empty pop means
	// the level seen by the pacer and the FIFO have drifted apart
	a_no_pop_empty: assert property (
		@(posedge CLK_114) disable iff (!rst_n)
		rd |-> level != '0
	) else $error("sample_fifo: pop while empty");

endmodule

`default_nettype wire

// ==== src/video_out.sv ====
// Video output stage, fixed 2-cycle latency for colour and syncs.
// Controls are levels and travel with the pixel through both stages.
// Syncs and colour are passed as given; blanking is the source's job.
`timescale 1ns/1ps
`default_nettype none

`include "mm_macros.svh"

module video_out import mm_av_pkg::*; (
	input wire CLK_114,
	input wire rst_n,
	input wire color_t src_r,
	input wire color_t src_g,
	input wire color_t src_b,
	input wire hsync_in,
	input wire vsync_in,
	input wire csync_in,
	input wire sel_csync, // Composite sync on the HS pin
	input wire hsync_pol,
	input wire vsync_pol,
	input wire osd_window, // Inside OSD box
	input wire osd_pixel, // OSD text pixel
	output logic [`MM_VGA_W-1:0] vga_r,
	output logic [`MM_VGA_W-1:0] vga_g,
	output logic [`MM_VGA_W-1:0] vga_b,
	output logic vga_hs,
	output logic vga_vs
);

	localparam int CW = `MM_COLOR_W;
	localparam int VW = `MM_VGA_W;

	osd_col_t osd_rg; // Same for red and green
	osd_col_t osd_b;
	color_t s1_r;
	color_t s1_g;
	color_t s1_b;
	logic s1_hs;
	logic s1_vs;
	logic s1_cs;
	logic s1_sel;
	logic s1_hpol;
	logic s1_vpol;

	// OSD colour on top, source shifted down under it
	function automatic color_t osd_mix(input color_t src, input osd_col_t osd, input logic win);
		return win ? {osd, src[CW-1:2]} : src;
	endfunction

	assign osd_rg = osd_pixel ? OSD_FG : OSD_BG_RG;
	assign osd_b = osd_pixel ? OSD_FG : OSD_BG_B;

	////////////////////////////////////////////////////////////
	// Stage 1, overlay and sync capture
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_114) begin
		s1_r <= osd_mix(src_r, osd_rg, osd_window);
		s1_g <= osd_mix(src_g, osd_rg, osd_window);
		s1_b <= osd_mix(src_b, osd_b, osd_window);
	end

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			s1_hs <= 1'b0;
			s1_vs <= 1'b0;
			s1_cs <= 1'b0;
			s1_sel <= 1'b0;
			s1_hpol <= 1'b0;
			s1_vpol <= 1'b0;
		end else begin
			s1_hs <= hsync_in;
			s1_vs <= vsync_in;
			s1_cs <= csync_in;
			s1_sel <= sel_csync; // Controls follow the pixel
			s1_hpol <= hsync_pol;
			s1_vpol <= vsync_pol;
		end
	end

	////////////////////////////////////////////////////////////
	// Stage 2, polarity and width cut
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			vga_hs <= s1_sel ? s1_cs : (s1_hs ^ s1_hpol);
			vga_vs <= s1_vs ^ (s1_vpol & ~s1_sel); // VS idle in csync mode
			vga_r <= s1_r[CW-1 -: VW]; // Keep the top bits
			vga_g <= s1_g[CW-1 -: VW];
			vga_b <= s1_b[CW-1 -: VW];
		end
	end

endmodule

`default_nettype wire

// ==== tests/tb_mm_top.sv ====
// Testbench for mm_top, all stimulus from one Galois LFSR with a fixed seed.
// Inputs change 1 ns after the rising edge, outputs are sampled on the falling edge.
// Audio and key models run every cycle through all tests, so the FIFO and key
// state carry over from one test to the next.
`timescale 1ns/1ps
`default_nettype none

`include "mm_macros.svh"

module tb_mm_top;

	logic CLK_114;
	logic rst_n;
	logic samp_wr;
	logic [`MM_SAMPLE_W-1:0] samp_data;
	logic mat_key_stb;
	logic [`MM_KEY_W-1:0] mat_key;
	logic dock_key_stb;
	logic [`MM_KEY_W-1:0] dock_key;
	logic [`MM_COLOR_W-1:0] src_r;
	logic [`MM_COLOR_W-1:0] src_g;
	logic [`MM_COLOR_W-1:0] src_b;
	logic hsync_in;
	logic vsync_in;
	logic csync_in;
	logic sel_csync;
	logic hsync_pol;
	logic vsync_pol;
	logic osd_window;
	logic osd_pixel;
	wire samp_full;
	wire [`MM_SAMPLE_W-1:0] aud_left;
	wire [`MM_SAMPLE_W-1:0] aud_right;
	wire aud_strobe;
	wire aud_underrun;
	wire [`MM_KEY_W-1:0] key_code;
	wire key_stb;
	wire [`MM_VGA_W-1:0] vga_r;
	wire [`MM_VGA_W-1:0] vga_g;
	wire [`MM_VGA_W-1:0] vga_b;
	wire vga_hs;
	wire vga_vs;

	logic [31:0] lfsr = 32'h8682_1864; // Fixed seed
	int test_no = 0;
	int checks = 0; // Per test
	int errors = 0;
	int total_checks = 0;
	int total_errors = 0;
	logic timed_out = 1'b0;
	int cyc = 0; // Falling edges seen
	int aud_mode = 0; // 0 idle, 1 paced writes, 2 flood
	logic key_on = 1'b0;

	logic [19:0] vid_q[$]; // {r, g, b, hs, vs} per driven cycle
	logic [`MM_SAMPLE_W-1:0] aud_q[$]; // Accepted words, oldest first
	logic [`MM_SAMPLE_W-1:0] exp_left = '0;
	logic [`MM_SAMPLE_W-1:0] exp_right = '0;
	logic wrote_last = 1'b0; // Write taken at the last edge
	int last_start = -1; // Cycle of the last period start
	int n_strobe = 0;
	int n_under = 0;
	int n_drop = 0;
	logic m_key_valid = 1'b0; // Key model, pending flag and code
	logic [`MM_KEY_W-1:0] m_key_code = '0;
	logic prev_mat_stb = 1'b0; // Last cycle's key drive
	logic [`MM_KEY_W-1:0] prev_mat = '0;
	logic prev_dock_stb = 1'b0;
	logic [`MM_KEY_W-1:0] prev_dock = '0;
	logic key_prev = 1'b0;
	logic [`MM_KEY_W-1:0] rise_code = '0;
	int key_hi = 0;
	int key_seen = 0;

	mm_top u_mm_top (
		.CLK_114 (CLK_114),
		.rst_n (rst_n),
		.samp_wr (samp_wr),
		.samp_data (samp_data),
		.samp_full (samp_full),
		.mat_key_stb (mat_key_stb),
		.mat_key (mat_key),
		.dock_key_stb (dock_key_stb),
		.dock_key (dock_key),
		.src_r (src_r),
		.src_g (src_g),
		.src_b (src_b),
		.hsync_in (hsync_in),
		.vsync_in (vsync_in),
		.csync_in (csync_in),
		.sel_csync (sel_csync),
		.hsync_pol (hsync_pol),
		.vsync_pol (vsync_pol),
		.osd_window (osd_window),
		.osd_pixel (osd_pixel),
		.aud_left (aud_left),
		.aud_right (aud_right),
		.aud_strobe (aud_strobe),
		.aud_underrun (aud_underrun),
		.key_code (key_code),
		.key_stb (key_stb),
		.vga_r (vga_r),
		.vga_g (vga_g),
		.vga_b (vga_b),
		.vga_hs (vga_hs),
		.vga_vs (vga_vs)
	);

	initial begin
		CLK_114 = 1'b0;
		forever #50 CLK_114 = ~CLK_114; // 100 ns period
	end

	////////////////////////////////////////////////////////////
	// Random source and reporting
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1); // Taps 32, 30, 26, 25
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	task automatic note_mismatch(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		errors++;
	endtask

	task automatic note_failure(input string what);
		$display("error at %0t: %s", $time, what);
		errors++;
	endtask

	task automatic begin_test();
		test_no++;
		checks = 0;
		errors = 0;
	endtask

	task automatic finish_test(input string name);
		$display("test %0d %s: %0d checks, %0d errors, %s", test_no, name, checks, errors,
			errors == 0 ? "ok" : "failed");
		total_checks += checks;
		total_errors += errors;
	endtask

	////////////////////////////////////////////////////////////
	// Reference models
	////////////////////////////////////////////////////////////

	// OSD colour in the top two bits, source moved down under it
	function automatic logic [7:0] overlay(input logic [7:0] c, input logic [1:0] osd);
		return {osd, c[7:2]};
	endfunction

	function automatic logic [19:0] expect_video();
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		logic [1:0] o_rg;
		logic [1:0] o_b;
		logic hs;
		logic vs;
		o_rg = osd_pixel ? 2'b11 : 2'b00; // White text on dark blue
		o_b = osd_pixel ? 2'b11 : 2'b10;
		r = osd_window ? overlay(src_r, o_rg) : src_r;
		g = osd_window ? overlay(src_g, o_rg) : src_g;
		b = osd_window ? overlay(src_b, o_b) : src_b;
		hs = sel_csync ? csync_in : (hsync_in ^ hsync_pol);
		vs = vsync_in ^ (vsync_pol & ~sel_csync);
		return {r[7:2], g[7:2], b[7:2], hs, vs}; // Top 6 bits to the DAC
	endfunction

	task automatic drive_inputs();
		logic [31:0] t;
		@(posedge CLK_114);
		#1;
		t = rand_bits(24);
		src_r = t[23:16];
		src_g = t[15:8];
		src_b = t[7:0];
		t = rand_bits(8);
		{hsync_in, vsync_in, csync_in, sel_csync} = t[3:0];
		{hsync_pol, vsync_pol, osd_window, osd_pixel} = t[7:4];
		mat_key_stb = 1'b0;
		dock_key_stb = 1'b0;
		if (key_on) begin
			t = rand_bits(22);
			mat_key_stb = (t[2:0] == 3'd0); // About one in eight
			mat_key = t[10:3];
			dock_key_stb = (t[13:11] == 3'd0);
			dock_key = t[21:14];
		end
		samp_wr = 1'b0;
		if (aud_mode == 1) begin
			t = rand_bits(20);
			samp_wr = (t[3:0] == 4'd0) && (aud_q.size() < `MM_FIFO_DEPTH - 2); // Never fills
			samp_data = t[19:4];
		end else if (aud_mode == 2) begin
			t = rand_bits(16);
			samp_wr = 1'b1; // Every cycle, full or not
			samp_data = t[15:0];
		end
	endtask

	task automatic observe_cycle();
		logic [19:0] exp_v;
		logic [`MM_SAMPLE_W-1:0] w;
		int start;
		logic exp_full;
		@(negedge CLK_114);
		cyc++;
		start = -1;
		// Video, two cycles behind the drive
		if (vid_q.size() >= 2) begin
			exp_v = vid_q.pop_front();
			checks += 2;
			if ({vga_r, vga_g, vga_b} !== exp_v[19:2])
				note_mismatch("vga colour", 32'({vga_r, vga_g, vga_b}), 32'(exp_v[19:2]));
			if ({vga_hs, vga_vs} !== exp_v[1:0])
				note_mismatch("vga syncs", 32'({vga_hs, vga_vs}), 32'(exp_v[1:0]));
		end
		vid_q.push_back(expect_video());
		// Keys, model holds the state before the latest edge
		if (key_stb && !key_prev) begin
			checks++;
			if (!m_key_valid)
				note_failure("key_stb rose with no key pending");
			else if (key_code !== m_key_code)
				note_mismatch("key_code", 32'(key_code), 32'(m_key_code));
			m_key_valid = 1'b0;
			rise_code = key_code;
			key_seen++;
		end
		if (key_stb) begin
			key_hi++;
			if (key_code !== rise_code)
				note_mismatch("key_code inside strobe", 32'(key_code), 32'(rise_code));
		end else if (key_prev) begin
			checks++;
			if (key_hi != `MM_KEY_DIV)
				note_mismatch("key_stb width", 32'(key_hi), 32'(`MM_KEY_DIV));
			key_hi = 0;
		end
		key_prev = key_stb;
		if (prev_mat_stb) begin // Matrix wins a collision
			m_key_valid = 1'b1;
			m_key_code = prev_mat;
		end else if (prev_dock_stb) begin
			m_key_valid = 1'b1;
			m_key_code = prev_dock;
		end
		prev_mat_stb = mat_key_stb;
		prev_mat = mat_key;
		prev_dock_stb = dock_key_stb;
		prev_dock = dock_key;
		// Audio pairs and underruns
		if (aud_strobe) begin
			start = cyc - 4; // Fixed latency from period start
			n_strobe++;
			checks++;
			if (aud_q.size() < 2) begin
				note_failure("audio pair strobed with fewer than two words written");
			end else begin
				w = aud_q.pop_front();
				exp_left = {w[7:0], w[15:8]};
				w = aud_q.pop_front();
				exp_right = {w[7:0], w[15:8]};
			end
		end
		if (aud_underrun) begin
			start = cyc - 1;
			n_under++;
			checks++;
			if (aud_q.size() - (wrote_last ? 1 : 0) >= 2) // Level seen at period start
				note_failure("underrun while a full pair was in the FIFO");
		end
		if (start >= 0) begin
			checks++;
			if (last_start >= 0 && start - last_start != `MM_AUD_PERIOD)
				note_mismatch("sample period", 32'(start - last_start), 32'(`MM_AUD_PERIOD));
			last_start = start;
		end
		checks++;
		if (aud_left !== exp_left || aud_right !== exp_right) // Held between strobes
			note_mismatch("audio pair", {aud_left, aud_right}, {exp_left, exp_right});
		// Writes only meet a full FIFO in the flood, where no pop is in flight
		wrote_last = 1'b0;
		if (samp_wr) begin
			exp_full = (aud_q.size() >= `MM_FIFO_DEPTH);
			checks++;
			if (samp_full !== exp_full)
				note_mismatch("samp_full", 32'(samp_full), 32'(exp_full));
			if (!exp_full) begin
				aud_q.push_back(samp_data);
				wrote_last = 1'b1;
			end else begin
				n_drop++; // Dropped by the FIFO, kept out of the model
			end
		end
	endtask

	task automatic run_cycles(input int n);
		repeat (n) begin
			drive_inputs();
			observe_cycle();
		end
	endtask

	task automatic wait_audio(input int strobes, input int unders, input string what);
		int s0;
		int u0;
		int n;
		s0 = n_strobe;
		u0 = n_under;
		n = 0;
		while ((n_strobe - s0 < strobes || n_under - u0 < unders) && !timed_out) begin
			run_cycles(1);
			n++;
			if (n > (strobes + unders + 4) * (`MM_AUD_PERIOD + 8)) begin
				timed_out = 1'b1;
				$display("timeout at %0t: no %s after %0d cycles", $time, what, n);
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int n;
		rst_n = 1'b0;
		samp_wr = 1'b0;
		samp_data = '0;
		mat_key_stb = 1'b0;
		mat_key = '0;
		dock_key_stb = 1'b0;
		dock_key = '0;
		{src_r, src_g, src_b} = '0;
		{hsync_in, vsync_in, csync_in, sel_csync} = '0;
		{hsync_pol, vsync_pol, osd_window, osd_pixel} = '0;
		repeat (3) @(posedge CLK_114);
		#1 rst_n = 1'b1;

		begin_test();
		run_cycles(500);
		finish_test("osd overlay");

		begin_test();
		run_cycles(500);
		finish_test("sync polarity and csync");

		begin_test();
		key_on = 1'b1;
		run_cycles(1500);
		key_on = 1'b0;
		run_cycles(1); // Last drive still to be captured
		n = 0;
		while ((m_key_valid || key_stb) && !timed_out) begin
			run_cycles(1);
			n++;
			if (n > 4 * `MM_KEY_DIV) begin
				timed_out = 1'b1;
				$display("timeout at %0t: pending key never delivered", $time);
			end
		end
		if (key_seen < 20)
			note_failure("too few key deliveries");
		finish_test("key merge");

		if (!timed_out) begin
			begin_test();
			aud_mode = 1;
			wait_audio(8, 0, "audio pair");
			finish_test("audio pairs");
		end

		if (!timed_out) begin
			begin_test();
			aud_mode = 0; // Starve the FIFO
			wait_audio(0, 2, "underrun");
			aud_mode = 2;
			run_cycles(40);
			if (n_drop == 0)
				note_failure("FIFO never overflowed");
			aud_mode = 1;
			wait_audio(4, 0, "audio pair after overflow");
			finish_test("underrun and overflow");
		end

		$display("totals: %0d tests, %0d checks, %0d errors%s", test_no, total_checks,
			total_errors, timed_out ? ", run stopped on timeout" : "");
		if (total_errors == 0 && !timed_out) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
